//--- common/rs_pkg.sv
package rs_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    localparam int XLEN  = 32;
    localparam int TAG_W = 5;

    // defaults for the top level only
    localparam int NUM_ALU_DEFAULT  = 4;
    localparam int NUM_MULT_DEFAULT = 2;

    typedef logic [XLEN-1:0]  xlen_t;

    // tag zero means no producer
    typedef logic [TAG_W-1:0] tag_t;

    //////////////////////////////
    // opcodes and packets
    //////////////////////////////

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_MUL
    } op_t;

    typedef struct packed {
        tag_t  tag;
        xlen_t value;
        logic  ready;
    } operand_t;

    typedef struct packed {
        op_t      op;
        operand_t src1;
        operand_t src2;
        tag_t     dest;
    } dispatch_t;

    // what a unit sees at start
    typedef struct packed {
        op_t   op;
        xlen_t a;
        xlen_t b;
    } issue_t;

    typedef struct packed {
        tag_t  tag;
        xlen_t value;
    } cdb_t;

    typedef enum logic [1:0] {
        SLOT_FREE,
        SLOT_WAIT,
        SLOT_EXEC,
        SLOT_DONE
    } slot_state_t;

endpackage

//--- fu/alu_unit.sv
`timescale 1ns/1ps

module alu_unit
    import rs_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   squash,

    input  logic   start,
    input  issue_t issue,

    output logic   done,
    output xlen_t  result,
    input  logic   grant
);

    xlen_t alu_out;

    always_comb begin
        case (issue.op)
            OP_ADD:  alu_out = issue.a + issue.b;
            OP_SUB:  alu_out = issue.a - issue.b;
            OP_AND:  alu_out = issue.a & issue.b;
            OP_OR:   alu_out = issue.a | issue.b;
            OP_XOR:  alu_out = issue.a ^ issue.b;
            // signed compare
            OP_SLT:  alu_out = xlen_t'($signed(issue.a) < $signed(issue.b));
            default: alu_out = '0;
        endcase
    end

    // held until the cdb takes it
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            done <= 1'b0;
        end else if (start) begin
            done <= 1'b1;
        end else if (grant) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (start)
            result <= alu_out;
    end

endmodule

//--- fu/mult_unit.sv
`timescale 1ns/1ps

module mult_unit
    import rs_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   squash,

    input  logic   start,
    input  issue_t issue,

    output logic   done,
    output xlen_t  result,
    input  logic   grant
);

    logic        s1_valid;
    logic        s2_valid;
    xlen_t       s1_a;
    xlen_t       s1_b;
    xlen_t       s2_lo;
    logic [15:0] s2_hi;

    //////////////////////////////
    // valid per stage
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            s1_valid <= start;
            s2_valid <= s1_valid;
            if (s2_valid)
                done <= 1'b1;
            else if (grant)
                done <= 1'b0;
        end
    end

    //////////////////////////////
    // datapath
    //////////////////////////////

    // stage 1 registers operands
    always_ff @(posedge clock) begin
        if (start) begin
            s1_a <= issue.a;
            s1_b <= issue.b;
        end
    end

    // stage 2 splits b into halves,
    // only the low 16 bits of the upper partial survive the shift
    always_ff @(posedge clock) begin
        s2_lo <= s1_a * {16'b0, s1_b[15:0]};
        s2_hi <= s1_a[15:0] * s1_b[31:16];
    end

    // stage 3 sums and holds for the cdb
    always_ff @(posedge clock) begin
        if (s2_valid)
            result <= s2_lo + {s2_hi, 16'b0};
    end

endmodule

//--- station/rs_slot_bank.sv
`timescale 1ns/1ps

module rs_slot_bank
    import rs_pkg::*;
#(
    parameter int num_alu  = 1,
    parameter int num_mult = 1
) (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               squash,

    input  logic                               dispatch_valid,
    input  dispatch_t                          dispatch,
    output logic                               dispatch_ready,

    input  logic                               wake_valid,
    input  cdb_t                               wake,

    output logic   [num_alu+num_mult-1:0]      start,
    output issue_t [num_alu+num_mult-1:0]      issue,
    input  logic   [num_alu+num_mult-1:0]      grant,
    output tag_t   [num_alu+num_mult-1:0]      dest_tag
);

    localparam int N     = num_alu + num_mult;
    localparam int IDX_W = $clog2(N);

    slot_state_t [N-1:0] state;
    op_t         [N-1:0] slot_op;
    operand_t    [N-1:0] src1;
    operand_t    [N-1:0] src2;
    tag_t        [N-1:0] dest;

    logic             is_mult;
    logic             alloc_found;
    logic [IDX_W-1:0] alloc_idx;
    logic             accept;

    // capture a broadcast value if this operand is waiting on it
    function automatic operand_t resolve(operand_t opnd, logic wv, cdb_t w);
        operand_t r;
        r = opnd;
        if (opnd.tag == '0) begin
            r.ready = 1'b1;
        end else if (!opnd.ready && wv && opnd.tag == w.tag) begin
            r.value = w.value;
            r.ready = 1'b1;
        end
        return r;
    endfunction

    //////////////////////////////
    // allocation
    //////////////////////////////

    // lowest free slot of the class from state at cycle start
    always_comb begin
        is_mult     = (dispatch.op == OP_MUL);
        alloc_found = 1'b0;
        alloc_idx   = '0;
        for (int i = 0; i < N; i++) begin
            if (!alloc_found && state[i] == SLOT_FREE && ((i >= num_alu) == is_mult)) begin
                alloc_found = 1'b1;
                alloc_idx   = IDX_W'(i);
            end
        end
    end

    assign dispatch_ready = alloc_found;
    assign accept         = dispatch_valid & alloc_found;

    always_comb begin
        for (int i = 0; i < N; i++) begin
            start[i]    = (state[i] == SLOT_WAIT) && src1[i].ready && src2[i].ready;
            issue[i].op = slot_op[i];
            issue[i].a  = src1[i].value;
            issue[i].b  = src2[i].value;
            dest_tag[i] = dest[i];
        end
    end

    //////////////////////////////
    // slot state
    //////////////////////////////

    always_ff @(posedge clock) begin
        for (int i = 0; i < N; i++) begin
            if (reset || squash) begin
                state[i] <= SLOT_FREE;
            end else begin
                case (state[i])
                    SLOT_FREE: begin
                        if (accept && int'(alloc_idx) == i)
                            state[i] <= SLOT_WAIT;
                    end
                    SLOT_WAIT: begin
                        if (start[i])
                            state[i] <= SLOT_EXEC;
                    end
                    default: begin
                        // the unit holds its result until the grant
                        if (grant[i])
                            state[i] <= SLOT_FREE;
                    end
                endcase
            end
        end
    end

    // operands and destination
    always_ff @(posedge clock) begin
        for (int i = 0; i < N; i++) begin
            if (accept && int'(alloc_idx) == i) begin
                slot_op[i] <= dispatch.op;
                dest[i]    <= dispatch.dest;
                src1[i]    <= resolve(dispatch.src1, wake_valid, wake);
                src2[i]    <= resolve(dispatch.src2, wake_valid, wake);
            end else begin
                src1[i] <= resolve(src1[i], wake_valid, wake);
                src2[i] <= resolve(src2[i], wake_valid, wake);
            end
        end
    end

endmodule

//--- hdl/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter
    import rs_pkg::*;
#(
    parameter int num_units = 2
) (
    input  logic                        clock,
    input  logic                        reset,

    input  logic  [num_units-1:0]       done,
    input  xlen_t [num_units-1:0]       result,
    input  tag_t  [num_units-1:0]       dest_tag,
    output logic  [num_units-1:0]       grant,

    output logic                        cdb_valid,
    output cdb_t                        cdb,
    input  logic                        cdb_ready
);

    localparam int IDX_W = (num_units > 1) ? $clog2(num_units) : 1;

    logic [IDX_W-1:0] ptr;
    logic [IDX_W-1:0] pick;
    logic [IDX_W-1:0] winner;
    logic [IDX_W-1:0] lock_idx;
    logic             lock;
    logic             transfer;

    // first done unit at or after the pointer
    always_comb begin
        int idx;
        pick = ptr;
        for (int k = num_units - 1; k >= 0; k--) begin
            idx = (int'(ptr) + k) % num_units;
            if (done[idx])
                pick = IDX_W'(idx);
        end
    end

    // keep the stalled choice unless a squash emptied it
    assign winner    = (lock && done[lock_idx]) ? lock_idx : pick;
    assign cdb_valid = |done;
    assign cdb.tag   = dest_tag[winner];
    assign cdb.value = result[winner];
    assign transfer  = cdb_valid & cdb_ready;

    always_comb begin
        grant         = '0;
        grant[winner] = transfer;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ptr  <= '0;
            lock <= 1'b0;
        end else begin
            lock <= cdb_valid & ~cdb_ready;
            if (transfer)
                ptr <= (int'(winner) == num_units - 1) ? '0 : winner + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        lock_idx <= winner;
    end

endmodule

//--- hdl/rs_top.sv
`timescale 1ns/1ps

module rs_top
    import rs_pkg::*;
#(
    parameter int num_alu  = NUM_ALU_DEFAULT,
    parameter int num_mult = NUM_MULT_DEFAULT
) (
    input  logic      clock,
    input  logic      reset,
    input  logic      squash,

    input  logic      dispatch_valid,
    input  dispatch_t dispatch,
    output logic      dispatch_ready,

    output logic      cdb_valid,
    output cdb_t      cdb,
    input  logic      cdb_ready
);

    localparam int num_slots = num_alu + num_mult;

    logic   [num_slots-1:0] start;
    issue_t [num_slots-1:0] issue;
    logic   [num_slots-1:0] done;
    xlen_t  [num_slots-1:0] result;
    logic   [num_slots-1:0] grant;
    tag_t   [num_slots-1:0] dest_tag;
    logic                   wake_valid;

    // only a completed transfer wakes waiting operands
    assign wake_valid = cdb_valid & cdb_ready;

    rs_slot_bank #(
        .num_alu  (num_alu),
        .num_mult (num_mult)
    ) u_slot_bank (
        .clock          (clock),
        .reset          (reset),
        .squash         (squash),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .wake_valid     (wake_valid),
        .wake           (cdb),
        .start          (start),
        .issue          (issue),
        .grant          (grant),
        .dest_tag       (dest_tag)
    );

    //////////////////////////////
    // units, alu slots first
    //////////////////////////////

    for (genvar i = 0; i < num_alu; i++) begin : g_alu
        alu_unit u_alu (
            .clock  (clock),
            .reset  (reset),
            .squash (squash),
            .start  (start[i]),
            .issue  (issue[i]),
            .done   (done[i]),
            .result (result[i]),
            .grant  (grant[i])
        );
    end

    for (genvar j = 0; j < num_mult; j++) begin : g_mult
        mult_unit u_mult (
            .clock  (clock),
            .reset  (reset),
            .squash (squash),
            .start  (start[num_alu+j]),
            .issue  (issue[num_alu+j]),
            .done   (done[num_alu+j]),
            .result (result[num_alu+j]),
            .grant  (grant[num_alu+j])
        );
    end

    cdb_arbiter #(
        .num_units (num_slots)
    ) u_arbiter (
        .clock     (clock),
        .reset     (reset),
        .done      (done),
        .result    (result),
        .dest_tag  (dest_tag),
        .grant     (grant),
        .cdb_valid (cdb_valid),
        .cdb       (cdb),
        .cdb_ready (cdb_ready)
    );

endmodule

//--- dv/tb_rs.sv
`timescale 1ns/1ps

module tb_rs
    import rs_pkg::*;
();

    localparam int wait_limit   = 400;
    localparam int ready_random = 0;
    localparam int ready_high   = 1;
    localparam int ready_low    = 2;
    localparam tag_t no_tag     = '0;

    // one row of stimulus
    // a nonzero source tag names an earlier dest
    typedef struct packed {
        op_t   op;
        tag_t  t1;
        xlen_t v1;
        tag_t  t2;
        xlen_t v2;
        tag_t  dest;
        xlen_t expected;
    } entry_t;

    logic      clock;
    logic      reset;
    logic      squash;
    logic      dispatch_valid;
    dispatch_t dispatch;
    logic      dispatch_ready;
    logic      cdb_valid;
    cdb_t      cdb;
    logic      cdb_ready;

    entry_t      table_q[$];
    xlen_t       ref_result [32];
    xlen_t       exp_val [32];
    logic        pending [32];
    logic        seen [32];
    int          outstanding;
    int          ready_mode;
    logic [31:0] rng;
    logic        stall_seen;
    cdb_t        stall_item;

    rs_top u_dut (
        .clock          (clock),
        .reset          (reset),
        .squash         (squash),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .cdb_valid      (cdb_valid),
        .cdb            (cdb),
        .cdb_ready      (cdb_ready)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    //////////////////////////////
    // reporting and checks
    //////////////////////////////

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic check_cdb(input string name, input cdb_t got, input cdb_t want);
        if (got !== want) begin
            $display("ERR %0t %s got tag %0d value %h, expected tag %0d value %h",
                     $time, name, got.tag, got.value, want.tag, want.value);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("ERR %0t %s got %b, expected %b", $time, name, got, want);
            stop_run();
        end
    endtask

    //////////////////////////////
    // reference model and table
    //////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] r;
        r = x ^ (x << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    function automatic xlen_t model_op(input op_t op, input xlen_t a, input xlen_t b);
        logic [63:0] product;
        product = 64'(a) * 64'(b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_MUL:  return product[31:0];
            default: return '0;
        endcase
    endfunction

    function automatic void add_entry(input op_t op, input tag_t t1, input xlen_t v1,
                                      input tag_t t2, input xlen_t v2, input tag_t dest);
        entry_t e;
        xlen_t  a;
        xlen_t  b;
        a          = (t1 != no_tag) ? ref_result[t1] : v1;
        b          = (t2 != no_tag) ? ref_result[t2] : v2;
        e.op       = op;
        e.t1       = t1;
        e.v1       = v1;
        e.t2       = t2;
        e.v2       = v2;
        e.dest     = dest;
        e.expected = model_op(op, a, b);
        ref_result[dest] = e.expected;
        table_q.push_back(e);
    endfunction

    task automatic fill_table();
        // independent alu ops in rows 0 to 5
        add_entry(OP_ADD, no_tag, 32'd100, no_tag, 32'd23, 5'd1);
        add_entry(OP_SUB, no_tag, 32'd5, no_tag, 32'd9, 5'd2);
        add_entry(OP_AND, no_tag, 32'hf0f0_1234, no_tag, 32'h0ff0_ff00, 5'd3);
        add_entry(OP_OR, no_tag, 32'h1200_0034, no_tag, 32'h0056_7800, 5'd4);
        add_entry(OP_XOR, no_tag, 32'hdead_beef, no_tag, 32'hffff_0000, 5'd5);
        add_entry(OP_SLT, no_tag, 32'hffff_fff0, no_tag, 32'd3, 5'd6);
        // multiplies in rows 6 to 9
        add_entry(OP_MUL, no_tag, 32'h1234_5678, no_tag, 32'h9abc_def0, 5'd7);
        add_entry(OP_MUL, no_tag, 32'hffff_ffff, no_tag, 32'hffff_ffff, 5'd8);
        add_entry(OP_MUL, no_tag, 32'h0001_0000, no_tag, 32'h0001_0000, 5'd9);
        add_entry(OP_MUL, no_tag, 32'h8000_0003, no_tag, 32'd7, 5'd10);
        // dependent chain in rows 10 to 15
        add_entry(OP_ADD, no_tag, 32'd5, no_tag, 32'd7, 5'd11);
        add_entry(OP_MUL, 5'd11, 32'd0, no_tag, 32'd3, 5'd12);
        add_entry(OP_SUB, 5'd12, 32'd0, 5'd11, 32'd0, 5'd13);
        add_entry(OP_SLT, no_tag, 32'hffff_ffff, 5'd13, 32'd0, 5'd14);
        add_entry(OP_XOR, 5'd12, 32'd0, 5'd14, 32'd0, 5'd15);
        add_entry(OP_MUL, 5'd15, 32'd0, 5'd13, 32'd0, 5'd16);
        // both classes filled in rows 16 to 21
        add_entry(OP_ADD, no_tag, 32'd1, no_tag, 32'd2, 5'd20);
        add_entry(OP_OR, no_tag, 32'h00f0, no_tag, 32'h0f00, 5'd21);
        add_entry(OP_SUB, no_tag, 32'd0, no_tag, 32'd1, 5'd22);
        add_entry(OP_AND, no_tag, 32'hffff, no_tag, 32'h1234_5678, 5'd23);
        add_entry(OP_MUL, no_tag, 32'd12345, no_tag, 32'd6789, 5'd24);
        add_entry(OP_MUL, no_tag, 32'h7fff_ffff, no_tag, 32'd2, 5'd25);
        // squashed in rows 22 to 24 with the mult class full
        add_entry(OP_ADD, no_tag, 32'd10, no_tag, 32'd20, 5'd26);
        add_entry(OP_MUL, no_tag, 32'd1, no_tag, 32'd2, 5'd27);
        add_entry(OP_MUL, no_tag, 32'd3, no_tag, 32'd4, 5'd28);
        // latency and bypass in rows 25 and 26
        add_entry(OP_XOR, no_tag, 32'h5555_aaaa, no_tag, 32'h0f0f_0f0f, 5'd29);
        add_entry(OP_SUB, 5'd29, 32'd0, no_tag, 32'd4, 5'd30);
    endtask

    //////////////////////////////
    // driving
    //////////////////////////////

    // resolved value once the producer has been broadcast
    function automatic operand_t make_operand(input tag_t t, input xlen_t v);
        operand_t o;
        o.tag   = no_tag;
        o.value = v;
        o.ready = 1'b1;
        if (t != no_tag && seen[t]) begin
            o.value = ref_result[t];
        end else if (t != no_tag) begin
            o.tag   = t;
            o.value = '0;
            o.ready = 1'b0;
        end
        return o;
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #10;
    endtask

    task automatic set_ready(input int mode);
        ready_mode = mode;
        next_cycle();
    endtask

    task automatic send(input entry_t e);
        logic accepted;
        int   waited;
        accepted        = 1'b0;
        waited          = 0;
        exp_val[e.dest] = e.expected;
        pending[e.dest] = 1'b1;
        outstanding++;
        dispatch_valid  = 1'b1;
        while (!accepted) begin
            dispatch.op   = e.op;
            dispatch.src1 = make_operand(e.t1, e.v1);
            dispatch.src2 = make_operand(e.t2, e.v2);
            dispatch.dest = e.dest;
            @(negedge clock);
            accepted = dispatch_ready;
            next_cycle();
            waited++;
            if (!accepted && waited > wait_limit)
                report_problem("timeout waiting for dispatch_ready");
        end
        dispatch_valid = 1'b0;
    endtask

    task automatic probe_ready(input string name, input op_t op, input logic want);
        dispatch.op = op;
        #1;
        check_flag(name, dispatch_ready, want);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (outstanding != 0) begin
            next_cycle();
            waited++;
            if (waited > wait_limit)
                report_problem("timeout waiting for CDB results to drain");
        end
    endtask

    task automatic wait_valid();
        int waited;
        waited = 0;
        while (!cdb_valid) begin
            next_cycle();
            waited++;
            if (waited > wait_limit)
                report_problem("timeout waiting for cdb_valid");
        end
    endtask

    // cdb back-pressure
    initial begin
        forever begin
            @(posedge clock);
            #10;
            rng = xorshift(rng);
            if (ready_mode == ready_high)
                cdb_ready = 1'b1;
            else if (ready_mode == ready_low)
                cdb_ready = 1'b0;
            else
                cdb_ready = (rng[1:0] != 2'b00);
        end
    end

    // scoreboard sampled mid cycle ahead of the transfer edge
    initial begin
        cdb_t want;
        forever begin
            @(negedge clock);
            if (reset || squash) begin
                stall_seen = 1'b0;
            end else begin
                if (stall_seen) begin
                    check_flag("cdb_valid", cdb_valid, 1'b1);
                    check_cdb("cdb", cdb, stall_item);
                end
                if (cdb_valid && cdb_ready) begin
                    if (!pending[cdb.tag])
                        report_problem($sformatf("unexpected CDB item for tag %0d at %0t",
                                                 cdb.tag, $time));
                    want.tag   = cdb.tag;
                    want.value = exp_val[cdb.tag];
                    check_cdb("cdb", cdb, want);
                    pending[cdb.tag] = 1'b0;
                    seen[cdb.tag]    = 1'b1;
                    outstanding--;
                end
                stall_seen = cdb_valid && !cdb_ready;
                stall_item = cdb;
            end
        end
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        cdb_t want;
        reset          = 1'b1;
        squash         = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        cdb_ready      = 1'b0;
        ready_mode     = ready_low;
        rng            = 32'ha32c;
        outstanding    = 0;
        stall_seen     = 1'b0;
        stall_item     = '0;
        for (int t = 0; t < 32; t++) begin
            pending[t]    = 1'b0;
            seen[t]       = 1'b0;
            exp_val[t]    = '0;
            ref_result[t] = '0;
        end
        fill_table();
        repeat (2) @(posedge clock);
        #10;
        reset = 1'b0;
        check_flag("cdb_valid", cdb_valid, 1'b0);
        probe_ready("dispatch_ready alu", OP_ADD, 1'b1);
        probe_ready("dispatch_ready mult", OP_MUL, 1'b1);

        // alu, mult and chains under random back-pressure
        set_ready(ready_random);
        for (int i = 0; i < 16; i++)
            send(table_q[i]);
        wait_drain();

        // class full with the cdb stalled
        set_ready(ready_low);
        for (int i = 16; i < 20; i++)
            send(table_q[i]);
        probe_ready("dispatch_ready alu", OP_ADD, 1'b0);
        probe_ready("dispatch_ready mult", OP_MUL, 1'b1);
        for (int i = 20; i < 22; i++)
            send(table_q[i]);
        probe_ready("dispatch_ready mult", OP_MUL, 1'b0);
        set_ready(ready_high);
        wait_drain();
        probe_ready("dispatch_ready alu", OP_ADD, 1'b1);
        probe_ready("dispatch_ready mult", OP_MUL, 1'b1);

        // squash
        set_ready(ready_low);
        for (int i = 22; i < 25; i++)
            send(table_q[i]);
        probe_ready("dispatch_ready mult", OP_MUL, 1'b0);
        wait_valid();
        squash = 1'b1;
        next_cycle();
        squash = 1'b0;
        for (int i = 22; i < 25; i++)
            pending[table_q[i].dest] = 1'b0;
        outstanding = 0;
        set_ready(ready_high);
        for (int k = 0; k < 8; k++) begin
            check_flag("cdb_valid", cdb_valid, 1'b0);
            next_cycle();
        end
        probe_ready("dispatch_ready alu", OP_ADD, 1'b1);
        probe_ready("dispatch_ready mult", OP_MUL, 1'b1);

        // two cycle alu latency
        // then a consumer lands on the broadcast edge
        send(table_q[25]);
        check_flag("cdb_valid", cdb_valid, 1'b0);
        next_cycle();
        want.tag   = table_q[25].dest;
        want.value = table_q[25].expected;
        check_flag("cdb_valid", cdb_valid, 1'b1);
        check_cdb("cdb", cdb, want);
        send(table_q[26]);
        wait_drain();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- src.f
common/rs_pkg.sv
fu/alu_unit.sv
fu/mult_unit.sv
station/rs_slot_bank.sv
hdl/cdb_arbiter.sv
hdl/rs_top.sv
dv/tb_rs.sv

//--- Makefile
# Verilator build for the reservation station

VERILATOR  ?= verilator
FILELIST   ?= src.f
TB_TOP     ?= tb_rs
RTL_TOP    ?= rs_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= ALL TESTS PASSED
VFLAGS     ?= --timing
LINT_FLAGS ?= -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
